// File: slice_fx_pkg.sv
package slice_fx_pkg;

    typedef logic [11:0] coord_t; // Screen coordinate.
    typedef logic [13:0] depth_t; // Smaller depth is nearer.

    // Cut direction of a block and motion direction of a fragment.
    // Codes 5 to 7 are not assigned.
    typedef enum logic [2:0] {
        UP    = 3'd0,
        RIGHT = 3'd1,
        DOWN  = 3'd2,
        LEFT  = 3'd3,
        ANY   = 3'd4
    } dir_t;

    // Fragment outline, a block cut in half.
    localparam coord_t SHORT_SIDE = 12'd64;
    localparam coord_t LONG_SIDE  = 12'd128;

endpackage

// File: slice_decoder.sv
module slice_decoder import slice_fx_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       block_sliced,
    input  coord_t     block_x,
    input  coord_t     block_y,
    input  depth_t     block_z,
    input  logic       block_color,
    input  logic [2:0] block_direction,
    output logic       frag_valid,
    output coord_t     frag_x,
    output coord_t     frag_y,
    output depth_t     frag_z,
    output logic       frag_color,
    output coord_t     frag_w,
    output coord_t     frag_h,
    output dir_t       frag_dir_a,
    output dir_t       frag_dir_b
);

    logic       sliced_q;
    coord_t     x_q;
    coord_t     y_q;
    depth_t     z_q;
    logic       color_q;
    logic [2:0] dir_q;
    logic       vertical_cut;

    // Input sample of the slice event.
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            sliced_q <= 1'b0;
        end else begin
            sliced_q <= block_sliced;
        end
    end

    always_ff @(posedge clk_in) begin
        if (block_sliced) begin
            x_q     <= block_x;
            y_q     <= block_y;
            z_q     <= block_z;
            color_q <= block_color;
            dir_q   <= block_direction;
        end
    end

    // ANY and unassigned codes fall through to a horizontal cut.
    assign vertical_cut = (dir_q == UP) || (dir_q == DOWN);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            frag_valid <= 1'b0;
        end else begin
            frag_valid <= sliced_q;
        end
    end

    always_ff @(posedge clk_in) begin
        if (sliced_q) begin
            frag_x     <= x_q;
            frag_y     <= y_q;
            frag_z     <= z_q;
            frag_color <= color_q;
            frag_w     <= vertical_cut ? SHORT_SIDE : LONG_SIDE;
            frag_h     <= vertical_cut ? LONG_SIDE : SHORT_SIDE;
            frag_dir_a <= vertical_cut ? LEFT : UP; // Halves push apart.
            frag_dir_b <= vertical_cut ? RIGHT : DOWN;
        end
    end

endmodule

// File: fragment_pool.sv
module fragment_pool import slice_fx_pkg::*; #(
    parameter int NUM_SLOTS      = 10,
    parameter int LIFETIME_TICKS = 50,
    parameter int STEP           = 8,
    parameter int FIELD_MAX      = 3599,
    parameter int TIME_W         = 18
) (
    input  logic                             clk_in,
    input  logic                             rst_in,
    input  logic   [TIME_W-1:0]              curr_time,
    input  logic                             frag_valid,
    input  coord_t                           frag_x,
    input  coord_t                           frag_y,
    input  depth_t                           frag_z,
    input  logic                             frag_color,
    input  coord_t                           frag_w,
    input  coord_t                           frag_h,
    input  dir_t                             frag_dir_a,
    input  dir_t                             frag_dir_b,
    output logic   [NUM_SLOTS-1:0]           slot_valid,
    output coord_t [NUM_SLOTS-1:0]           slot_x,
    output coord_t [NUM_SLOTS-1:0]           slot_y,
    output depth_t [NUM_SLOTS-1:0]           slot_z,
    output coord_t [NUM_SLOTS-1:0]           slot_w,
    output coord_t [NUM_SLOTS-1:0]           slot_h,
    output logic   [NUM_SLOTS-1:0]           slot_color,
    output logic   [$clog2(NUM_SLOTS+1)-1:0] live_count
);

    localparam int     AGE_W   = $clog2(LIFETIME_TICKS + 1);
    localparam int     CNT_W   = $clog2(NUM_SLOTS + 1);
    localparam coord_t STEP_C  = coord_t'(STEP);
    localparam coord_t LIMIT_C = coord_t'(FIELD_MAX);

    dir_t   [NUM_SLOTS-1:0]            slot_dir;
    logic   [NUM_SLOTS-1:0][AGE_W-1:0] slot_age;
    logic   [TIME_W-1:0]               last_time;
    logic                              tick;

    logic   [NUM_SLOTS-1:0]            valid_nxt;
    coord_t [NUM_SLOTS-1:0]            x_nxt;
    coord_t [NUM_SLOTS-1:0]            y_nxt;
    depth_t [NUM_SLOTS-1:0]            z_nxt;
    coord_t [NUM_SLOTS-1:0]            w_nxt;
    coord_t [NUM_SLOTS-1:0]            h_nxt;
    logic   [NUM_SLOTS-1:0]            color_nxt;
    dir_t   [NUM_SLOTS-1:0]            dir_nxt;
    logic   [NUM_SLOTS-1:0][AGE_W-1:0] age_nxt;
    logic   [TIME_W-1:0]               time_nxt;
    logic   [CNT_W-1:0]                count_nxt;

    assign tick = (curr_time != last_time); // Any change of game time.

    always_comb begin
        valid_nxt = slot_valid;
        x_nxt     = slot_x;
        y_nxt     = slot_y;
        z_nxt     = slot_z;
        w_nxt     = slot_w;
        h_nxt     = slot_h;
        color_nxt = slot_color;
        dir_nxt   = slot_dir;
        age_nxt   = slot_age;
        time_nxt  = last_time;
        if (frag_valid) begin
            // Shift down by a pair, oldest pair drops out. Tick waits a cycle.
            for (int i = 0; i < NUM_SLOTS - 2; i++) begin
                valid_nxt[i] = slot_valid[i + 2];
                x_nxt[i]     = slot_x[i + 2];
                y_nxt[i]     = slot_y[i + 2];
                z_nxt[i]     = slot_z[i + 2];
                w_nxt[i]     = slot_w[i + 2];
                h_nxt[i]     = slot_h[i + 2];
                color_nxt[i] = slot_color[i + 2];
                dir_nxt[i]   = slot_dir[i + 2];
                age_nxt[i]   = slot_age[i + 2];
            end
            for (int i = NUM_SLOTS - 2; i < NUM_SLOTS; i++) begin
                valid_nxt[i] = 1'b1;
                x_nxt[i]     = frag_x;
                y_nxt[i]     = frag_y;
                z_nxt[i]     = frag_z;
                w_nxt[i]     = frag_w;
                h_nxt[i]     = frag_h;
                color_nxt[i] = frag_color;
                age_nxt[i]   = '0;
            end
            dir_nxt[NUM_SLOTS-2] = frag_dir_a;
            dir_nxt[NUM_SLOTS-1] = frag_dir_b;
        end else if (tick) begin
            time_nxt = curr_time;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (slot_valid[i]) begin
                    if (slot_age[i] == AGE_W'(LIFETIME_TICKS)) begin
                        valid_nxt[i] = 1'b0; // Lifetime used up.
                    end else begin
                        age_nxt[i] = slot_age[i] + 1'b1;
                        case (slot_dir[i])
                            UP: begin
                                y_nxt[i] = (slot_y[i] < STEP_C) ? '0 : slot_y[i] - STEP_C;
                            end
                            DOWN: begin
                                y_nxt[i] = (slot_y[i] > LIMIT_C - STEP_C) ?
                                           LIMIT_C : slot_y[i] + STEP_C;
                            end
                            LEFT: begin
                                x_nxt[i] = (slot_x[i] < STEP_C) ? '0 : slot_x[i] - STEP_C;
                            end
                            RIGHT: begin
                                x_nxt[i] = (slot_x[i] > LIMIT_C - STEP_C) ?
                                           LIMIT_C : slot_x[i] + STEP_C;
                            end
                            default: begin
                            end
                        endcase
                    end
                end
            end
        end
    end

    // Count taken from next state so it tracks the slots on the same edge.
    always_comb begin
        count_nxt = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            count_nxt = count_nxt + CNT_W'(valid_nxt[i]);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            slot_valid <= '0;
            live_count <= '0;
            last_time  <= '0;
        end else begin
            slot_valid <= valid_nxt;
            live_count <= count_nxt;
            last_time  <= time_nxt;
        end
    end

    always_ff @(posedge clk_in) begin
        slot_x     <= x_nxt;
        slot_y     <= y_nxt;
        slot_z     <= z_nxt;
        slot_w     <= w_nxt;
        slot_h     <= h_nxt;
        slot_color <= color_nxt;
        slot_dir   <= dir_nxt;
        slot_age   <= age_nxt;
    end

endmodule

// File: pixel_compositor.sv
module pixel_compositor import slice_fx_pkg::*; #(
    parameter int NUM_SLOTS = 10
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   query_valid,
    input  coord_t                 query_x,
    input  coord_t                 query_y,
    input  logic   [NUM_SLOTS-1:0] slot_valid,
    input  coord_t [NUM_SLOTS-1:0] slot_x,
    input  coord_t [NUM_SLOTS-1:0] slot_y,
    input  depth_t [NUM_SLOTS-1:0] slot_z,
    input  coord_t [NUM_SLOTS-1:0] slot_w,
    input  coord_t [NUM_SLOTS-1:0] slot_h,
    input  logic   [NUM_SLOTS-1:0] slot_color,
    output logic                   result_valid,
    output logic                   result_hit,
    output logic                   result_color,
    output depth_t                 result_z
);

    logic                   query_q;
    coord_t                 qx_q;
    coord_t                 qy_q;
    logic   [NUM_SLOTS-1:0] covers;

    logic                   valid_s1;
    logic   [NUM_SLOTS-1:0] cover_s1;
    depth_t [NUM_SLOTS-1:0] z_s1;
    logic   [NUM_SLOTS-1:0] color_s1;

    logic                   found;
    depth_t                 best_z;
    logic                   best_color;

    // Query sample.
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            query_q <= 1'b0;
        end else begin
            query_q <= query_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        qx_q <= query_x;
        qy_q <= query_y;
    end

    // Right and bottom edges are exclusive. Sums use 13 bits.
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            covers[i] = slot_valid[i]
                && (slot_x[i] <= qx_q) && (13'(qx_q) < 13'(slot_x[i]) + 13'(slot_w[i]))
                && (slot_y[i] <= qy_q) && (13'(qy_q) < 13'(slot_y[i]) + 13'(slot_h[i]));
        end
    end

    // Stage one.
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= query_q;
        end
    end

    always_ff @(posedge clk_in) begin
        cover_s1 <= covers;
        z_s1     <= slot_z;
        color_s1 <= slot_color;
    end

    // Nearest wins. Strict compare keeps the lowest index on a tie.
    always_comb begin
        found      = 1'b0;
        best_z     = '0;
        best_color = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (cover_s1[i] && (!found || z_s1[i] < best_z)) begin
                found      = 1'b1;
                best_z     = z_s1[i];
                best_color = color_s1[i];
            end
        end
    end

    // Stage two.
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= valid_s1;
        end
    end

    always_ff @(posedge clk_in) begin
        result_hit   <= found;
        result_color <= best_color; // Zero on a miss.
        result_z     <= best_z;
    end

endmodule

// File: slice_fx_top.sv
module slice_fx_top import slice_fx_pkg::*; #(
    parameter int NUM_SLOTS      = 10,
    parameter int LIFETIME_TICKS = 50,
    parameter int STEP           = 8,
    parameter int FIELD_MAX      = 3599,
    parameter int TIME_W         = 18
) (
    input  logic                             clk_in,
    input  logic                             rst_in,
    input  logic   [TIME_W-1:0]              curr_time,
    input  logic                             block_sliced,
    input  coord_t                           block_x,
    input  coord_t                           block_y,
    input  depth_t                           block_z,
    input  logic                             block_color,
    input  logic   [2:0]                     block_direction,
    input  logic                             query_valid,
    input  coord_t                           query_x,
    input  coord_t                           query_y,
    output logic                             result_valid,
    output logic                             result_hit,
    output logic                             result_color,
    output depth_t                           result_z,
    output logic   [$clog2(NUM_SLOTS+1)-1:0] live_count
);

    logic                   frag_valid;
    coord_t                 frag_x;
    coord_t                 frag_y;
    depth_t                 frag_z;
    logic                   frag_color;
    coord_t                 frag_w;
    coord_t                 frag_h;
    dir_t                   frag_dir_a;
    dir_t                   frag_dir_b;

    logic   [NUM_SLOTS-1:0] slot_valid;
    coord_t [NUM_SLOTS-1:0] slot_x;
    coord_t [NUM_SLOTS-1:0] slot_y;
    depth_t [NUM_SLOTS-1:0] slot_z;
    coord_t [NUM_SLOTS-1:0] slot_w;
    coord_t [NUM_SLOTS-1:0] slot_h;
    logic   [NUM_SLOTS-1:0] slot_color;

    slice_decoder u_decoder (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .block_sliced    (block_sliced),
        .block_x         (block_x),
        .block_y         (block_y),
        .block_z         (block_z),
        .block_color     (block_color),
        .block_direction (block_direction),
        .frag_valid      (frag_valid),
        .frag_x          (frag_x),
        .frag_y          (frag_y),
        .frag_z          (frag_z),
        .frag_color      (frag_color),
        .frag_w          (frag_w),
        .frag_h          (frag_h),
        .frag_dir_a      (frag_dir_a),
        .frag_dir_b      (frag_dir_b)
    );

    fragment_pool #(
        .NUM_SLOTS      (NUM_SLOTS),
        .LIFETIME_TICKS (LIFETIME_TICKS),
        .STEP           (STEP),
        .FIELD_MAX      (FIELD_MAX),
        .TIME_W         (TIME_W)
    ) u_pool (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .curr_time  (curr_time),
        .frag_valid (frag_valid),
        .frag_x     (frag_x),
        .frag_y     (frag_y),
        .frag_z     (frag_z),
        .frag_color (frag_color),
        .frag_w     (frag_w),
        .frag_h     (frag_h),
        .frag_dir_a (frag_dir_a),
        .frag_dir_b (frag_dir_b),
        .slot_valid (slot_valid),
        .slot_x     (slot_x),
        .slot_y     (slot_y),
        .slot_z     (slot_z),
        .slot_w     (slot_w),
        .slot_h     (slot_h),
        .slot_color (slot_color),
        .live_count (live_count)
    );

    pixel_compositor #(
        .NUM_SLOTS (NUM_SLOTS)
    ) u_compositor (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .query_valid  (query_valid),
        .query_x      (query_x),
        .query_y      (query_y),
        .slot_valid   (slot_valid),
        .slot_x       (slot_x),
        .slot_y       (slot_y),
        .slot_z       (slot_z),
        .slot_w       (slot_w),
        .slot_h       (slot_h),
        .slot_color   (slot_color),
        .result_valid (result_valid),
        .result_hit   (result_hit),
        .result_color (result_color),
        .result_z     (result_z)
    );

endmodule

// File: tb_slice_fx.sv
module tb_slice_fx import slice_fx_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD    = 4;
    localparam int    RESET_CYCLES  = 8;
    localparam int    QUERY_LATENCY = 3;
    localparam string STIM_FILE     = "slice_fx_stimulus.txt";

    logic        clk_in;
    logic        rst_in;
    logic [17:0] curr_time;
    logic        block_sliced;
    coord_t      block_x;
    coord_t      block_y;
    depth_t      block_z;
    logic        block_color;
    logic [2:0]  block_direction;
    logic        query_valid;
    coord_t      query_x;
    coord_t      query_y;
    logic        result_valid;
    logic        result_hit;
    logic        result_color;
    depth_t      result_z;
    logic [3:0]  live_count;

    logic [15:0] expected_q[$]; // {hit, color, depth} per query in flight.
    int          issued_q[$];
    int          cycle_count  = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    slice_fx_top UUT (.*);

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s expected 0x%0h got 0x%0h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic end_run();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    function automatic int count_lines();
        int            fd;
        int            n;
        logic [1023:0] line_text;
        n  = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            return 0;
        end
        while ($fgets(line_text, fd) != 0) begin
            n++;
        end
        $fclose(fd);
        return n;
    endfunction

    task automatic apply_slice(input int x, input int y, input int z, input int color,
                               input int dir, input int t);
        logic deferred;
        @(negedge clk_in);
        block_sliced    = 1'b1;
        block_x         = 12'(x);
        block_y         = 12'(y);
        block_z         = 14'(z);
        block_color     = 1'(color);
        block_direction = 3'(dir);
        @(negedge clk_in);
        block_sliced = 1'b0;
        @(negedge clk_in);
        deferred  = (18'(t) != curr_time);
        curr_time = 18'(t); // Changes on the edge where the pair lands.
        @(negedge clk_in);
        if (deferred) begin
            @(negedge clk_in); // Deferred tick.
        end
    endtask

    // One tick per step.
    task automatic step_time(input int target);
        while (curr_time != 18'(target)) begin
            @(negedge clk_in);
            curr_time = curr_time + 18'd1;
            @(negedge clk_in);
        end
    endtask

    task automatic send_query(input int x, input int y, input int hit, input int color,
                              input int z);
        @(negedge clk_in);
        query_valid = 1'b1;
        query_x     = 12'(x);
        query_y     = 12'(y);
        expected_q.push_back({1'(hit), 1'(color), 14'(z)});
        issued_q.push_back(cycle_count);
    endtask

    task automatic finish_queries();
        int waited;
        waited = 0;
        @(negedge clk_in);
        query_valid = 1'b0;
        while (expected_q.size() > 0 && waited < 10) begin
            @(posedge clk_in);
            waited++;
        end
        if (expected_q.size() > 0) begin
            $display("No result_valid came for %0d queries in flight", expected_q.size());
            other_errors++;
            expected_q.delete();
            issued_q.delete();
        end
    endtask

    // Result monitor.
    always @(negedge clk_in) begin
        logic [15:0] expected;
        int          issued;
        if (result_valid) begin
            if (expected_q.size() == 0) begin
                $display("A result_valid came with no query in flight");
                other_errors++;
            end else begin
                expected = expected_q.pop_front();
                issued   = issued_q.pop_front();
                // Sampled on the next edge, valid two edges after that.
                check_value("result_valid latency", 32'(QUERY_LATENCY),
                            32'(cycle_count - issued));
                check_value("result_hit", 32'(expected[15]), 32'(result_hit));
                check_value("result_color", 32'(expected[14]), 32'(result_color));
                check_value("result_z", 32'(expected[13:0]), 32'(result_z));
            end
        end
    end

    initial begin : main
        int           fd;
        int           n;
        int           v0, v1, v2, v3, v4, v5;
        logic [63:0]  cmd;
        logic [1023:0] rest;
        bit           stop;
        rst_in          = 1'b1;
        curr_time       = '0;
        block_sliced    = 1'b0;
        block_x         = '0;
        block_y         = '0;
        block_z         = '0;
        block_color     = 1'b0;
        block_direction = '0;
        query_valid     = 1'b0;
        query_x         = '0;
        query_y         = '0;
        stop            = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_in);
        rst_in = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open %s", STIM_FILE);
            other_errors++;
        end else begin
            while (!stop) begin
                cmd = '0;
                n   = $fscanf(fd, "%s", cmd);
                if (n != 1) begin
                    stop = 1'b1;
                end else if (cmd == "#") begin
                    n = $fgets(rest, fd);
                end else begin
                    if (cmd != "Q" && query_valid) begin
                        finish_queries();
                    end
                    if (cmd == "S") begin
                        n = $fscanf(fd, "%d %d %d %d %d %d", v0, v1, v2, v3, v4, v5);
                        apply_slice(v0, v1, v2, v3, v4, v5);
                    end else if (cmd == "T") begin
                        n = $fscanf(fd, "%d", v0);
                        step_time(v0);
                    end else if (cmd == "C") begin
                        n = $fscanf(fd, "%d", v0);
                        @(negedge clk_in);
                        check_value("live_count", 32'(v0), 32'(live_count));
                    end else if (cmd == "Q") begin
                        n = $fscanf(fd, "%d %d %d %d %d", v0, v1, v2, v3, v4);
                        send_query(v0, v1, v2, v3, v4);
                    end else begin
                        $display("Unknown command in the stimulus file, reading stopped");
                        other_errors++;
                        stop = 1'b1;
                    end
                end
            end
            $fclose(fd);
        end
        if (query_valid) begin
            finish_queries();
        end
        end_run();
    end

    // Budget of 8 cycles per stimulus line.
    initial begin : watchdog
        int limit;
        limit = count_lines() * 8 + RESET_CYCLES;
        #(limit * CLK_PERIOD);
        $display("Timeout after %0d cycles, the stimulus did not complete", limit);
        other_errors++;
        end_run();
    end

endmodule

// File: slice_fx_stimulus.txt
# S x y depth color dir time | T time | C live_count | Q x y hit color depth
# S time is curr_time on the cycle the pair reaches the pool, T steps curr_time by one
C 0
Q 500 500 0 0 0
S 1000 1000 300 1 0 0
C 2
Q 1000 1000 1 1 300
Q 1063 1127 1 1 300
Q 1064 1050 0 0 0
T 3
C 2
Q 976 1000 1 1 300
Q 975 1000 0 0 0
Q 1087 1127 1 1 300
Q 1088 1000 0 0 0
# Clamping at 0 and at FIELD_MAX
S 8 200 500 0 2 3
S 2000 3590 600 1 1 3
C 6
T 5
C 6
Q 0 200 1 0 500
Q 70 250 1 0 500
Q 88 250 0 0 0
Q 2050 3662 1 1 600
Q 2050 3663 0 0 0
Q 2050 3574 1 1 600
# Nearer horizontal pair over the first one
S 950 1050 100 0 4 5
C 8
Q 1000 1060 1 0 100
Q 1000 1020 1 1 300
Q 1050 1100 1 0 100
Q 1100 1100 1 1 300
S 200 2000 700 1 0 5
S 500 2500 800 0 1 5
S 3000 100 200 1 0 5
S 3000 100 200 0 3 5
S 1500 1500 900 1 2 5
S 2500 500 50 0 7 5
C 10
Q 970 1010 0 0 0
Q 210 2010 0 0 0
Q 3010 110 1 1 200
Q 3100 110 1 0 200
Q 1563 1627 1 1 900
Q 1564 1600 0 0 0
Q 2627 563 1 0 50
Q 2600 564 0 0 0
# Slice and tick on the same edge
S 1200 3000 400 1 0 6
C 10
Q 1192 3000 1 1 400
Q 1271 3000 1 1 400
Q 1272 3000 0 0 0
T 30
S 100 100 1000 0 4 30
T 55
C 10
Q 800 3000 1 1 400
Q 799 3000 0 0 0
T 56
C 2
Q 800 3000 0 0 0
Q 150 0 1 0 1000
Q 150 308 1 0 1000
Q 150 200 0 0 0

// File: slice_fx.f
slice_fx_pkg.sv
slice_decoder.sv
fragment_pool.sv
pixel_compositor.sv
slice_fx_top.sv
tb_slice_fx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the slice effects testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal -j 0 \
    --top-module tb_slice_fx -f slice_fx.f -o sim_slice_fx
./obj_dir/sim_slice_fx | tee "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    echo "Run failed, see $LOG"
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "Run ended without a result, see $LOG"
    exit 1
fi
echo "Run passed"
